/* hdl/cabinet_pkg.sv */
/*
 * Shared types, key codes and bit indices for the cabinet control logic.
 * Every RTL block pulls these in by wildcard import.
 */
package cabinet_pkg;

	// Video timing selection
	typedef enum logic [0:0] {
		VIDEO_57HZ = 1'b0,
		VIDEO_60HZ = 1'b1
	} video_timing_e;

	typedef logic [7:0]  byte_t;
	typedef logic [15:0] joy_word_t;
	typedef logic [11:0] kb_buttons_t;
	typedef logic [5:0]  pll_addr_t;
	typedef logic [31:0] pll_word_t;

	// PS/2 event word
	// Bit 10 toggles per event, bit 9 is pressed, bit 8 extended, 7:0 code
	typedef logic [10:0] ps2_event_t;
	localparam int PS2_TOGGLE  = 10;
	localparam int PS2_PRESSED = 9;

	// Held keyboard button positions
	localparam int KB_START1 = 0;
	localparam int KB_START2 = 1;
	localparam int KB_COIN1  = 2;
	localparam int KB_COIN2  = 3;
	localparam int KB_PAUSE  = 4;
	localparam int KB_UP     = 5;
	localparam int KB_DOWN   = 6;
	localparam int KB_LEFT   = 7;
	localparam int KB_RIGHT  = 8;
	localparam int KB_SHOT   = 9;
	localparam int KB_JUMP   = 10;
	localparam int KB_SPARE  = 11;

	// PS/2 set 2 make codes of the mapped keys
	localparam byte_t KEY_1     = 8'h16;
	localparam byte_t KEY_2     = 8'h1E;
	localparam byte_t KEY_5     = 8'h2E;
	localparam byte_t KEY_6     = 8'h36;
	localparam byte_t KEY_P     = 8'h4D;
	localparam byte_t KEY_UP    = 8'h75;
	localparam byte_t KEY_DOWN  = 8'h72;
	localparam byte_t KEY_LEFT  = 8'h6B;
	localparam byte_t KEY_RIGHT = 8'h74;
	localparam byte_t KEY_CTRL  = 8'h14;
	localparam byte_t KEY_ALT   = 8'h11;

	// Controller word bits, USB and DB15 share the low ones
	localparam int JOY_RIGHT  = 0;
	localparam int JOY_LEFT   = 1;
	localparam int JOY_DOWN   = 2;
	localparam int JOY_UP     = 3;
	localparam int JOY_SHOT   = 4;
	localparam int JOY_JUMP   = 5;
	localparam int JOY_START  = 6;
	localparam int JOY_COIN   = 7;
	localparam int JOY_START2 = 8;
	localparam int JOY_PAUSE  = 9;
	// DB15 pad only
	localparam int DB_C      = 6;
	localparam int DB_START  = 10;
	localparam int DB_SELECT = 11;

	// Pairs per PLL table
	localparam int PLL_PARAM_COUNT = 9;

	// Download port indexes
	localparam byte_t DIP_INDEX  = 8'd254;
	localparam byte_t GAME_INDEX = 8'd1;

endpackage

/* hdl/pll_param_rom.sv */
/*
 * Fixed PLL configuration pairs for both video timings.
 * Combinational lookup by latched timing and pair index.
 */
module pll_param_rom import cabinet_pkg::*; (
	input  video_timing_e timing_lat,
	input  logic [3:0]    param_idx,
	output pll_addr_t     rom_addr,
	output pll_word_t     rom_data
);

	// Register addresses, same order for both timings
	localparam pll_addr_t ADDR_TBL [PLL_PARAM_COUNT] = '{
		6'h00,          // Waitrequest mode
		6'h04,          // M counter
		6'h03,          // N counter
		6'h05,          // C0 counter
		6'h05,          // C1 counter
		6'h09,          // Charge pump
		6'h08,          // Bandwidth
		6'h07,          // M fraction
		6'h02           // Start reconfig
	};

	// 48 / 96 MHz for native refresh
	localparam pll_word_t DATA_57HZ [PLL_PARAM_COUNT] = '{
		32'h0000_0000, 32'h0002_0504, 32'h0001_0000,
		32'h0000_0505, 32'h0006_0302, 32'h0000_0002,
		32'h0000_0007, 32'h9999_999A, 32'h0000_0001
	};

	// 50.135 / 100.27 MHz for standard 60 Hz
	localparam pll_word_t DATA_60HZ [PLL_PARAM_COUNT] = '{
		32'h0000_0000, 32'h0000_0A0A, 32'h0001_0000,
		32'h0000_0A0A, 32'h0004_0505, 32'h0000_0002,
		32'h0000_0007, 32'h0DD3_FDC4, 32'h0000_0001
	};

	always_comb begin
		rom_addr = '0;
		rom_data = '0;
		// Out of range index reads as zero
		if (param_idx < 4'(PLL_PARAM_COUNT)) begin
			rom_addr = ADDR_TBL[param_idx];
			if (timing_lat == VIDEO_60HZ)
				rom_data = DATA_60HZ[param_idx];
			else
				rom_data = DATA_57HZ[param_idx];
		end
	end

endmodule

/* hdl/pll_reconfig_ctrl.sv */
/*
 * PLL reconfiguration sequencer. A video timing change starts a fixed pause,
 * then nine table writes go out on the configuration port.
 */
module pll_reconfig_ctrl import cabinet_pkg::*; #(
	parameter int unsigned RECONFIG_WAIT_BITS = 8
) (
	input  logic          MS_CLK,
	input  logic          arst_n,
	input  logic          pll_locked,
	input  logic          cfg_waitrequest,
	input  video_timing_e timing_sel,
	input  pll_addr_t     rom_addr,
	input  pll_word_t     rom_data,
	output video_timing_e timing_lat,
	output logic [3:0]    param_idx,
	output logic          cfg_write,
	output pll_addr_t     cfg_address,
	output pll_word_t     cfg_data,
	output logic          reconfig_pause,
	output logic          pll_init_locked
);

	logic                          cfg_en;
	logic                          wait_done;
	logic                          last_pair;
	logic [RECONFIG_WAIT_BITS-1:0] wait_cnt;

	// Only advance with PLL locked and port ready
	assign cfg_en    = pll_locked & ~cfg_waitrequest;
	// All ones ends the pause and opens the write phase
	assign wait_done = &wait_cnt;
	assign last_pair = (param_idx == 4'(PLL_PARAM_COUNT - 1));

	//////////////////////////////////////////////////////////////////////
	// Control
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge MS_CLK or negedge arst_n) begin
		if (!arst_n) begin
			timing_lat      <= VIDEO_57HZ;
			wait_cnt        <= '0;
			param_idx       <= '0;
			cfg_write       <= 1'b0;
			reconfig_pause  <= 1'b0;
			pll_init_locked <= 1'b0;
		end else begin
			// Write strobe lasts one cycle
			cfg_write <= 1'b0;
			if (cfg_en) begin
				pll_init_locked <= 1'b1;
				if (wait_done) begin
					// Write phase
					cfg_write <= 1'b1;
					if (last_pair) begin
						param_idx <= '0;
						wait_cnt  <= '0;
					end else begin
						param_idx <= param_idx + 4'd1;
					end
				end else if (timing_sel != timing_lat) begin
					// New timing requested
					timing_lat     <= timing_sel;
					wait_cnt       <= RECONFIG_WAIT_BITS'(1);
					reconfig_pause <= 1'b1;
				end else if (|wait_cnt) begin
					// Pausing before the writes
					wait_cnt <= wait_cnt + RECONFIG_WAIT_BITS'(1);
				end else begin
					// Pass done and timing stable
					reconfig_pause <= 1'b0;
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Port payload
	//////////////////////////////////////////////////////////////////////

	// Pair for the current index, valid alongside cfg_write
	always_ff @(posedge MS_CLK) begin
		if (cfg_en && wait_done) begin
			cfg_address <= rom_addr;
			cfg_data    <= rom_data;
		end
	end

endmodule

/* hdl/ps2_button_latch.sv */
/*
 * Keyboard button latch. Each new PS/2 event on a mapped key sets
 * that button to the event's pressed bit.
 */
module ps2_button_latch import cabinet_pkg::*; (
	input  logic        MS_CLK,
	input  logic        arst_n,
	input  ps2_event_t  ps2_key,
	output kb_buttons_t kb_buttons
);

	logic  old_toggle;
	logic  new_event;
	logic  pressed;
	byte_t code;

	// A flip of the toggle bit marks a fresh event
	assign new_event = (ps2_key[PS2_TOGGLE] != old_toggle);
	assign pressed   = ps2_key[PS2_PRESSED];
	assign code      = ps2_key[7:0];

	always_ff @(posedge MS_CLK or negedge arst_n) begin
		if (!arst_n) begin
			old_toggle <= 1'b0;
			kb_buttons <= '0;
		end else begin
			old_toggle <= ps2_key[PS2_TOGGLE];
			// No key drives the spare slot
			kb_buttons[KB_SPARE] <= 1'b0;
			if (new_event) begin
				case (code)
					KEY_1:     kb_buttons[KB_START1] <= pressed;
					KEY_2:     kb_buttons[KB_START2] <= pressed;
					KEY_5:     kb_buttons[KB_COIN1]  <= pressed;
					KEY_6:     kb_buttons[KB_COIN2]  <= pressed;
					KEY_P:     kb_buttons[KB_PAUSE]  <= pressed;
					// Cursor keys
					KEY_UP:    kb_buttons[KB_UP]     <= pressed;
					KEY_DOWN:  kb_buttons[KB_DOWN]   <= pressed;
					KEY_LEFT:  kb_buttons[KB_LEFT]   <= pressed;
					KEY_RIGHT: kb_buttons[KB_RIGHT]  <= pressed;
					// Fire buttons
					KEY_CTRL:  kb_buttons[KB_SHOT]   <= pressed;
					KEY_ALT:   kb_buttons[KB_JUMP]   <= pressed;
					// Other keys are ignored
					default: ;
				endcase
			end
		end
	end

endmodule

/* hdl/player_input_encoder.sv */
/*
 * Merges keyboard, USB and DB15 controls into the two active-low player
 * bytes and the active-high pause level, registered once.
 */
module player_input_encoder import cabinet_pkg::*; (
	input  logic        MS_CLK,
	input  logic        arst_n,
	input  kb_buttons_t kb_buttons,
	input  joy_word_t   joystick_0,
	input  joy_word_t   joystick_1,
	input  joy_word_t   joy_db1,
	input  joy_word_t   joy_db2,
	input  logic [1:0]  snac_dev,
	output byte_t       player1,
	output byte_t       player2,
	output logic        pause
);

	joy_word_t db1;
	joy_word_t db2;
	byte_t     p1_act;
	byte_t     p2_act;
	logic      pause_act;

	// Jump, shot, down, up, left, right for one player, active high
	function automatic logic [5:0] ctrl_bits(joy_word_t db, joy_word_t js, kb_buttons_t kb);
		logic [5:0] bits;
		bits[5] = db[JOY_JUMP]  | kb[KB_JUMP]  | js[JOY_JUMP];
		bits[4] = db[JOY_SHOT]  | kb[KB_SHOT]  | js[JOY_SHOT];
		bits[3] = db[JOY_DOWN]  | kb[KB_DOWN]  | js[JOY_DOWN];
		bits[2] = db[JOY_UP]    | kb[KB_UP]    | js[JOY_UP];
		bits[1] = db[JOY_LEFT]  | kb[KB_LEFT]  | js[JOY_LEFT];
		bits[0] = db[JOY_RIGHT] | kb[KB_RIGHT] | js[JOY_RIGHT];
		return bits;
	endfunction

	// DB15 pads only count when enabled
	assign db1 = snac_dev[0] ? joy_db1 : '0;
	assign db2 = snac_dev[1] ? joy_db2 : '0;

	// Player 1 top bits are the start buttons
	// DB15 pad 1 button C doubles as start 2
	assign p1_act[7] = db2[DB_START] | db1[DB_C] | kb_buttons[KB_START2] |
		joystick_0[JOY_START2] | joystick_1[JOY_START2];
	assign p1_act[6] = db1[DB_START] | kb_buttons[KB_START1] |
		joystick_0[JOY_START] | joystick_1[JOY_START];
	assign p1_act[5:0] = ctrl_bits(db1, joystick_0, kb_buttons);

	// Player 2 top bits are the coins
	assign p2_act[7] = db2[DB_SELECT] | kb_buttons[KB_COIN2] | joystick_1[JOY_COIN];
	assign p2_act[6] = db1[DB_SELECT] | kb_buttons[KB_COIN1] | joystick_0[JOY_COIN];
	assign p2_act[5:0] = ctrl_bits(db2, joystick_1, kb_buttons);

	// Shot plus start on a DB15 pad requests pause
	assign pause_act = (db1[JOY_SHOT] & db1[DB_START]) |
		(db2[JOY_SHOT] & db2[DB_START]) |
		kb_buttons[KB_PAUSE] | joystick_0[JOY_PAUSE] | joystick_1[JOY_PAUSE];

	always_ff @(posedge MS_CLK or negedge arst_n) begin
		if (!arst_n) begin
			player1 <= '1;
			player2 <= '1;
			pause   <= 1'b0;
		end else begin
			// Cabinet inputs are active low
			player1 <= ~p1_act;
			player2 <= ~p2_act;
			pause   <= pause_act;
		end
	end

endmodule

/* hdl/dip_switch_bank.sv */
/*
 * DIP switch banks and game byte loaded from the download port.
 * Banks 0 and 1 feed the two switch outputs.
 */
module dip_switch_bank import cabinet_pkg::*; #(
	parameter int unsigned DIP_BANKS = 8
) (
	input  logic        MS_CLK,
	input  logic        arst_n,
	input  logic        ioctl_wr,
	input  byte_t       ioctl_index,
	input  logic [24:0] ioctl_addr,
	input  byte_t       ioctl_dout,
	output byte_t       dsw1,
	output byte_t       dsw2,
	output byte_t       game
);

	localparam int BANK_W = (DIP_BANKS > 1) ? $clog2(DIP_BANKS) : 1;

	byte_t sw [DIP_BANKS];
	logic  dip_wr;
	logic  game_wr;

	// Bank writes only inside the bank range
	assign dip_wr  = ioctl_wr && (ioctl_index == DIP_INDEX) &&
		(ioctl_addr < 25'(DIP_BANKS));
	assign game_wr = ioctl_wr && (ioctl_index == GAME_INDEX) && (ioctl_addr == '0);

	always_ff @(posedge MS_CLK or negedge arst_n) begin
		if (!arst_n) begin
			sw   <= '{default: '0};
			game <= '0;
		end else begin
			if (dip_wr)
				sw[ioctl_addr[BANK_W-1:0]] <= ioctl_dout;
			// Game select for multi-game sets
			if (game_wr)
				game <= ioctl_dout;
		end
	end

	assign dsw1 = sw[0];
	assign dsw2 = sw[1];

endmodule

/* hdl/cabinet_io_top.sv */
/*
 * Cabinet-side control top level. PLL reconfiguration sequencer with its
 * table, plus keyboard, player input and DIP switch datapaths.
 */
module cabinet_io_top import cabinet_pkg::*; #(
	parameter int unsigned RECONFIG_WAIT_BITS = 8,
	parameter int unsigned DIP_BANKS          = 8
) (
	input  logic          MS_CLK,
	input  logic          arst_n,

	// PLL configuration port
	input  logic          pll_locked,
	input  logic          cfg_waitrequest,
	input  video_timing_e timing_sel,
	output logic          cfg_write,
	output pll_addr_t     cfg_address,
	output pll_word_t     cfg_data,
	output logic          reconfig_pause,
	output logic          pll_init_locked,

	// Control sources
	input  ps2_event_t    ps2_key,
	input  joy_word_t     joystick_0,
	input  joy_word_t     joystick_1,
	input  joy_word_t     joy_db1,
	input  joy_word_t     joy_db2,
	input  logic [1:0]    snac_dev,

	// Download port
	input  logic          ioctl_wr,
	input  byte_t         ioctl_index,
	input  logic [24:0]   ioctl_addr,
	input  byte_t         ioctl_dout,

	// Game inputs, active low players
	output byte_t         player1,
	output byte_t         player2,
	output logic          pause,
	output byte_t         dsw1,
	output byte_t         dsw2,
	output byte_t         game
);

	video_timing_e timing_lat;
	logic [3:0]    param_idx;
	pll_addr_t     rom_addr;
	pll_word_t     rom_data;
	kb_buttons_t   kb_buttons;

	//////////////////////////////////////////////////////////////////////
	// PLL reconfiguration
	//////////////////////////////////////////////////////////////////////

	pll_reconfig_ctrl #(
		.RECONFIG_WAIT_BITS(RECONFIG_WAIT_BITS)
	) i_reconfig (
		.MS_CLK          (MS_CLK),
		.arst_n          (arst_n),
		.pll_locked      (pll_locked),
		.cfg_waitrequest (cfg_waitrequest),
		.timing_sel      (timing_sel),
		.rom_addr        (rom_addr),
		.rom_data        (rom_data),
		.timing_lat      (timing_lat),
		.param_idx       (param_idx),
		.cfg_write       (cfg_write),
		.cfg_address     (cfg_address),
		.cfg_data        (cfg_data),
		.reconfig_pause  (reconfig_pause),
		.pll_init_locked (pll_init_locked)
	);

	pll_param_rom i_param_rom (
		.timing_lat (timing_lat),
		.param_idx  (param_idx),
		.rom_addr   (rom_addr),
		.rom_data   (rom_data)
	);

	//////////////////////////////////////////////////////////////////////
	// Inputs
	//////////////////////////////////////////////////////////////////////

	ps2_button_latch i_kb (
		.MS_CLK     (MS_CLK),
		.arst_n     (arst_n),
		.ps2_key    (ps2_key),
		.kb_buttons (kb_buttons)
	);

	player_input_encoder i_players (
		.MS_CLK     (MS_CLK),
		.arst_n     (arst_n),
		.kb_buttons (kb_buttons),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.joy_db1    (joy_db1),
		.joy_db2    (joy_db2),
		.snac_dev   (snac_dev),
		.player1    (player1),
		.player2    (player2),
		.pause      (pause)
	);

	dip_switch_bank #(
		.DIP_BANKS(DIP_BANKS)
	) i_dip (
		.MS_CLK      (MS_CLK),
		.arst_n      (arst_n),
		.ioctl_wr    (ioctl_wr),
		.ioctl_index (ioctl_index),
		.ioctl_addr  (ioctl_addr),
		.ioctl_dout  (ioctl_dout),
		.dsw1        (dsw1),
		.dsw2        (dsw2),
		.game        (game)
	);

endmodule

/* test/cabinet_io_props.sv */
/*
 * Sequencer checks, bound into every pll_reconfig_ctrl instance.
 * Failures count up in assert_fails for the testbench verdict.
 */
module cabinet_io_props (
	input logic MS_CLK,
	input logic arst_n,
	input logic pll_locked,
	input logic cfg_waitrequest,
	input logic cfg_write,
	input logic reconfig_pause,
	input logic pll_init_locked
);

	int assert_fails = 0;

	// Writes only go out during a pause
	a_write_in_pause: assert property (@(posedge MS_CLK) disable iff (!arst_n)
		cfg_write |-> reconfig_pause)
	else begin
		$error("cfg_write high while reconfig_pause is low");
		assert_fails++;
	end

	// A stalled edge leaves the strobe low
	a_no_write_after_stall: assert property (@(posedge MS_CLK) disable iff (!arst_n)
		!(pll_locked && !cfg_waitrequest) |=> !cfg_write)
	else begin
		$error("cfg_write high after a stalled edge");
		assert_fails++;
	end

	// Sticky once set
	a_init_stays: assert property (@(posedge MS_CLK) disable iff (!arst_n)
		pll_init_locked |=> pll_init_locked)
	else begin
		$error("pll_init_locked fell");
		assert_fails++;
	end

endmodule

/* test/tb_cabinet_io.sv */
/*
 * Testbench for the cabinet control top level. Xorshift stimulus,
 * every output compared each cycle against a cycle model.
 */
module tb_cabinet_io import cabinet_pkg::*; ();

	localparam int WAIT_LIMIT = 4000;

	// Reference PLL pairs
	localparam pll_addr_t REF_ADDR [9] = '{
		6'h00, 6'h04, 6'h03, 6'h05, 6'h05, 6'h09, 6'h08, 6'h07, 6'h02
	};
	localparam pll_word_t REF_57HZ [9] = '{
		32'h0000_0000, 32'h0002_0504, 32'h0001_0000, 32'h0000_0505, 32'h0006_0302,
		32'h0000_0002, 32'h0000_0007, 32'h9999_999A, 32'h0000_0001
	};
	localparam pll_word_t REF_60HZ [9] = '{
		32'h0000_0000, 32'h0000_0A0A, 32'h0001_0000, 32'h0000_0A0A, 32'h0004_0505,
		32'h0000_0002, 32'h0000_0007, 32'h0DD3_FDC4, 32'h0000_0001
	};

	// Mapped keys and their buttons
	localparam byte_t KEY_CODES [11] = '{KEY_1, KEY_2, KEY_5, KEY_6, KEY_P,
		KEY_UP, KEY_DOWN, KEY_LEFT, KEY_RIGHT, KEY_CTRL, KEY_ALT};
	localparam int KEY_BTNS [11] = '{KB_START1, KB_START2, KB_COIN1, KB_COIN2, KB_PAUSE,
		KB_UP, KB_DOWN, KB_LEFT, KB_RIGHT, KB_SHOT, KB_JUMP};
	// Player byte bits 0 to 5: right, left, up, down, shot, jump
	localparam int CTRL_JOY [6] = '{JOY_RIGHT, JOY_LEFT, JOY_UP, JOY_DOWN, JOY_SHOT, JOY_JUMP};
	localparam int CTRL_KB [6] = '{KB_RIGHT, KB_LEFT, KB_UP, KB_DOWN, KB_SHOT, KB_JUMP};

	logic MS_CLK = 1'b0;
	logic arst_n;
	logic pll_locked, cfg_waitrequest, cfg_write, reconfig_pause, pll_init_locked;
	video_timing_e timing_sel;
	pll_addr_t cfg_address;
	pll_word_t cfg_data;
	ps2_event_t ps2_key;
	joy_word_t joystick_0, joystick_1, joy_db1, joy_db2;
	logic [1:0] snac_dev;
	logic ioctl_wr;
	byte_t ioctl_index, ioctl_dout;
	logic [24:0] ioctl_addr;
	byte_t player1, player2, dsw1, dsw2, game;
	logic pause;

	// Model state
	kb_buttons_t m_kb;
	logic m_toggle, m_pause, m_write, m_rpause, m_init;
	byte_t m_p1, m_p2, m_game;
	byte_t m_sw [8];
	video_timing_e m_lat;
	logic [7:0] m_cnt;
	int m_idx;
	pll_addr_t m_addr;
	pll_word_t m_data;
	logic [31:0] rng = 32'd38820;

	cabinet_io_top i_dut (.*);

	bind pll_reconfig_ctrl cabinet_io_props i_props (
		.MS_CLK(MS_CLK), .arst_n(arst_n), .pll_locked(pll_locked),
		.cfg_waitrequest(cfg_waitrequest), .cfg_write(cfg_write),
		.reconfig_pause(reconfig_pause), .pll_init_locked(pll_init_locked)
	);

	always #20 MS_CLK = ~MS_CLK;

	function automatic logic [31:0] next_random();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Cycle model
	//////////////////////////////////////////////////////////////////////

	task automatic model_reset();
		m_kb = '0;
		m_toggle = 1'b0;
		m_p1 = 8'hFF;
		m_p2 = 8'hFF;
		m_pause = 1'b0;
		m_sw = '{default: '0};
		m_game = '0;
		m_lat = VIDEO_57HZ;
		m_cnt = '0;
		m_idx = 0;
		{m_write, m_rpause, m_init} = 3'b000;
	endtask

	// Inputs read here are the ones the DUT samples on this edge
	task automatic model_step();
		joy_word_t d1;
		joy_word_t d2;
		byte_t a1;
		byte_t a2;
		d1 = snac_dev[0] ? joy_db1 : '0;
		d2 = snac_dev[1] ? joy_db2 : '0;
		// Encoder sees buttons held before this edge
		for (int i = 0; i < 6; i++) begin
			a1[i] = d1[CTRL_JOY[i]] | m_kb[CTRL_KB[i]] | joystick_0[CTRL_JOY[i]];
			a2[i] = d2[CTRL_JOY[i]] | m_kb[CTRL_KB[i]] | joystick_1[CTRL_JOY[i]];
		end
		a1[7] = d2[DB_START] | d1[DB_C] | m_kb[KB_START2] |
			joystick_0[JOY_START2] | joystick_1[JOY_START2];
		a1[6] = d1[DB_START] | m_kb[KB_START1] | joystick_0[JOY_START] | joystick_1[JOY_START];
		a2[7] = d2[DB_SELECT] | m_kb[KB_COIN2] | joystick_1[JOY_COIN];
		a2[6] = d1[DB_SELECT] | m_kb[KB_COIN1] | joystick_0[JOY_COIN];
		m_p1 = ~a1;
		m_p2 = ~a2;
		m_pause = (d1[JOY_SHOT] & d1[DB_START]) | (d2[JOY_SHOT] & d2[DB_START]) |
			m_kb[KB_PAUSE] | joystick_0[JOY_PAUSE] | joystick_1[JOY_PAUSE];
		// Keyboard latch
		if (ps2_key[PS2_TOGGLE] != m_toggle)
			for (int k = 0; k < 11; k++)
				if (ps2_key[7:0] == KEY_CODES[k])
					m_kb[KEY_BTNS[k]] = ps2_key[PS2_PRESSED];
		m_toggle = ps2_key[PS2_TOGGLE];
		// Download port
		if (ioctl_wr && ioctl_index == DIP_INDEX && ioctl_addr < 25'd8)
			m_sw[ioctl_addr[2:0]] = ioctl_dout;
		if (ioctl_wr && ioctl_index == GAME_INDEX && ioctl_addr == '0)
			m_game = ioctl_dout;
		// Sequencer, frozen on stalled edges
		m_write = 1'b0;
		if (pll_locked && !cfg_waitrequest) begin
			m_init = 1'b1;
			if (m_cnt == 8'hFF) begin
				m_write = 1'b1;
				m_addr = REF_ADDR[m_idx];
				m_data = (m_lat == VIDEO_60HZ) ? REF_60HZ[m_idx] : REF_57HZ[m_idx];
				m_idx++;
				if (m_idx == 9) begin
					m_idx = 0;
					m_cnt = '0;
				end
			end else if (timing_sel != m_lat) begin
				m_lat = timing_sel;
				m_cnt = 8'd1;
				m_rpause = 1'b1;
				m_idx = 0;
			end else if (m_cnt != 0) begin
				m_cnt++;
			end else begin
				m_rpause = 1'b0;
			end
		end
	endtask

	always @(posedge MS_CLK) begin
		if (!arst_n)
			model_reset();
		else
			model_step();
	end

	//////////////////////////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic fail_plain(input string msg);
		$display("Error at %0t: %s", $time, msg);
		$display("Test failures found");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Fail at %0t: %s got %b expected %b", $time, name, got, exp);
			$display("Test failures found");
			$fatal(1, "stopped at first error");
		end
	endtask

	task automatic check_byte(input string name, input byte_t got, input byte_t exp);
		if (got !== exp) begin
			$display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
			$display("Test failures found");
			$fatal(1, "stopped at first error");
		end
	endtask

	task automatic check_pll(input pll_addr_t got_addr, input pll_word_t got_data,
		input pll_addr_t exp_addr, input pll_word_t exp_data);
		if (got_addr !== exp_addr || got_data !== exp_data) begin
			$display("Fail at %0t: cfg_address/cfg_data got %h/%h expected %h/%h",
				$time, got_addr, got_data, exp_addr, exp_data);
			$display("Test failures found");
			$fatal(1, "stopped at first error");
		end
	endtask

	// Outputs are stable at the falling edge
	always @(negedge MS_CLK) begin
		if (i_dut.i_reconfig.i_props.assert_fails != 0)
			fail_plain("a sequencer assertion failed");
		check_bit("cfg_write", cfg_write, m_write);
		if (m_write)
			check_pll(cfg_address, cfg_data, m_addr, m_data);
		check_bit("reconfig_pause", reconfig_pause, m_rpause);
		check_bit("pll_init_locked", pll_init_locked, m_init);
		check_byte("player1", player1, m_p1);
		check_byte("player2", player2, m_p2);
		check_bit("pause", pause, m_pause);
		check_byte("dsw1", dsw1, m_sw[0]);
		check_byte("dsw2", dsw2, m_sw[1]);
		check_byte("game", game, m_game);
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	// Flip the timing, then follow the pause through its nine writes
	task automatic run_reconfig(input bit stalls);
		logic [31:0] r;
		int cycles;
		int writes;
		int first_wr;
		int last_wr;
		bit done;
		{cycles, writes, first_wr, last_wr, done} = '0;
		@(posedge MS_CLK);
		timing_sel <= (timing_sel == VIDEO_57HZ) ? VIDEO_60HZ : VIDEO_57HZ;
		for (int n = 0; n < 8 && !done; n++) begin
			@(negedge MS_CLK);
			done = reconfig_pause;
		end
		if (!done)
			fail_plain("reconfig_pause did not rise after a timing change");
		done = 1'b0;
		for (int n = 0; n < WAIT_LIMIT && !done; n++) begin
			@(posedge MS_CLK);
			if (stalls) begin
				r = next_random();
				pll_locked <= (r[1:0] != 2'd0);
				cfg_waitrequest <= (r[3:2] == 2'd0);
			end
			@(negedge MS_CLK);
			cycles++;
			if (cfg_write) begin
				if (writes == 0)
					first_wr = cycles;
				last_wr = cycles;
				writes++;
			end
			done = !reconfig_pause;
		end
		if (!done)
			fail_plain("timeout waiting for reconfig_pause to fall");
		if (writes != 9)
			fail_plain($sformatf("saw %0d PLL writes instead of 9", writes));
		// 255 enabled edges of pause, then back-to-back writes
		if (!stalls && (first_wr != 255 || last_wr != first_wr + 8))
			fail_plain("PLL writes did not follow the pause back to back");
		@(posedge MS_CLK);
		pll_locked <= 1'b1;
		cfg_waitrequest <= 1'b0;
	endtask

	initial begin
		logic [31:0] r;
		logic [31:0] s;
		model_reset();
		arst_n = 1'b0;
		{pll_locked, cfg_waitrequest, ioctl_wr} = 3'b000;
		timing_sel = VIDEO_57HZ;
		ps2_key = '0;
		{joystick_0, joystick_1, joy_db1, joy_db2} = '0;
		snac_dev = 2'b00;
		ioctl_index = '0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		repeat (4) @(posedge MS_CLK);
		arst_n <= 1'b1;
		pll_locked <= 1'b1;

		// Keyboard only, half the codes mapped
		repeat (300) begin
			@(posedge MS_CLK);
			r = next_random();
			ps2_key <= {r[20], r[21], r[22],
				r[0] ? KEY_CODES[r[11:8] % 11] : byte_t'(r[31:24])};
		end

		// Sparse controller words with random DB15 enables
		repeat (300) begin
			@(posedge MS_CLK);
			r = next_random();
			s = next_random();
			joystick_0 <= r[15:0] & s[15:0] & s[31:16];
			joystick_1 <= r[31:16] & s[15:0] & s[31:16];
			r = next_random();
			s = next_random();
			joy_db1 <= r[15:0] & s[15:0];
			joy_db2 <= r[31:16] & s[31:16];
			snac_dev <= r[5:4];
		end
		@(posedge MS_CLK);
		{joystick_0, joystick_1, joy_db1, joy_db2} <= '0;

		// Downloads, with foreign indexes and out of range addresses
		repeat (600) begin
			@(posedge MS_CLK);
			r = next_random();
			s = next_random();
			ioctl_wr <= r[0];
			ioctl_index <= (r[2:1] == 2'd3) ? byte_t'(r[31:24]) :
				(r[1] ? DIP_INDEX : GAME_INDEX);
			ioctl_addr <= r[3] ? 25'(r[6:4]) : (r[7] ? 25'(r[11:8]) : s[24:0]);
			ioctl_dout <= r[19:12];
		end
		@(posedge MS_CLK);
		ioctl_wr <= 1'b0;

		run_reconfig(1'b0);
		run_reconfig(1'b1);
		repeat (4) @(posedge MS_CLK);

		if (i_dut.i_reconfig.i_props.assert_fails == 0) begin
			$display("All tests passed!");
			$finish;
		end else begin
			$display("Test failures found");
			$fatal(1, "assertion failures during the run");
		end
	end

endmodule

/* verilog.f */
hdl/cabinet_pkg.sv
hdl/pll_param_rom.sv
hdl/pll_reconfig_ctrl.sv
hdl/ps2_button_latch.sv
hdl/player_input_encoder.sv
hdl/dip_switch_bank.sv
hdl/cabinet_io_top.sv
test/cabinet_io_props.sv
test/tb_cabinet_io.sv
